/* rtl/ipu_settings.svh */
`ifndef IPU_SETTINGS_SVH
`define IPU_SETTINGS_SVH

// ----------------------------------------
// Slave register window
// ----------------------------------------
`define IPU_REG_BASE     32'h4008_0000
`define IPU_OFS_CTRL     9'h000
`define IPU_OFS_STATE    9'h004
`define IPU_OFS_V_RANGE  9'h010
`define IPU_OFS_SEG      9'h028
`define IPU_OFS_PIX_IN   9'h100

// First word of the output frame buffer
`define IPU_OUT_BASE     32'h5000_0000

// ----------------------------------------
// Frame and field sizes
// ----------------------------------------
`define IPU_FRAME_W      320
`define IPU_FRAME_H      240

`define IPU_BUS_W        32
`define IPU_CHAN_W       4
`define IPU_CNT_W        17
`define IPU_SEG_W        8

// Clock cycles per display scan step
`define IPU_SEG_DIV      50_000

`endif

/* rtl/ipu_pkg.sv */
`include "ipu_settings.svh"

package ipu_pkg;

    typedef logic [`IPU_BUS_W-1:0]    addr_t;
    typedef logic [`IPU_BUS_W-1:0]    word_t;
    typedef logic [`IPU_CHAN_W-1:0]   chan_t;
    typedef logic [3*`IPU_CHAN_W-1:0] rgb_t;
    typedef logic [`IPU_CNT_W-1:0]    pix_cnt_t;
    typedef logic [`IPU_SEG_W-1:0]    seg_t;

    // Unlisted codes behave as original
    typedef enum logic [3:0] {
        MODE_ORIGINAL = 4'd0,
        MODE_BINARIZE = 4'd1
    } ipu_mode_e;

    typedef enum logic [1:0] {
        FS_IDLE,
        FS_RUN,
        FS_END
    } frame_state_e;

    typedef struct packed {
        logic       sel;
        logic [1:0] trans;
        logic       write;
        addr_t      addr;
    } ahb_req_t;

    typedef struct packed {
        ipu_mode_e mode;
        chan_t     v_min;
        chan_t     v_max;
    } ipu_cfg_t;

    typedef struct packed {
        logic valid;
        rgb_t data;
    } pix_beat_t;

    // Field order matches STATE bits 2..0
    typedef struct packed {
        logic output_done;
        logic input_done;
        logic running;
    } ipu_status_t;

    // Segment a in bit 0, decimal point off
    function automatic seg_t seg_hex(logic [3:0] digit);
        case (digit)
            4'h0:    return 8'h3F;
            4'h1:    return 8'h06;
            4'h2:    return 8'h5B;
            4'h3:    return 8'h4F;
            4'h4:    return 8'h66;
            4'h5:    return 8'h6D;
            4'h6:    return 8'h7D;
            4'h7:    return 8'h07;
            4'h8:    return 8'h7F;
            4'h9:    return 8'h6F;
            4'hA:    return 8'h77;
            4'hB:    return 8'h7C;
            4'hC:    return 8'h39;
            4'hD:    return 8'h5E;
            4'hE:    return 8'h79;
            default: return 8'h71;
        endcase
    endfunction

endpackage

/* rtl/ipu_regs.sv */
`timescale 1ns/1ps
`include "ipu_settings.svh"

module ipu_regs
    import ipu_pkg::*;
(
    input  logic        HCLK,
    input  logic        HRESETn,
    input  logic        HSELM,
    input  logic [1:0]  HTRANSM,
    input  logic        HWRITEM,
    input  addr_t       HADDRM,
    input  word_t       HWDATAM,
    output logic        HREADYOUTM,
    output word_t       HRDATAM,
    input  ipu_status_t status,
    input  logic        pix_ready,
    output ipu_cfg_t    cfg,
    output logic        restart,
    output pix_beat_t   pix_in,
    output word_t       seg_word
);

    localparam addr_t      REG_BASE    = `IPU_REG_BASE;
    localparam logic [6:0] IDX_CTRL    = 7'(`IPU_OFS_CTRL >> 2);
    localparam logic [6:0] IDX_STATE   = 7'(`IPU_OFS_STATE >> 2);
    localparam logic [6:0] IDX_V_RANGE = 7'(`IPU_OFS_V_RANGE >> 2);
    localparam logic [6:0] IDX_SEG     = 7'(`IPU_OFS_SEG >> 2);
    localparam logic [6:0] IDX_PIX     = 7'(`IPU_OFS_PIX_IN >> 2);

    ahb_req_t   req_now;
    ahb_req_t   req_q;
    logic       dp_wr;
    logic [6:0] dp_idx;
    logic       wr_ctrl;
    logic       wr_vrange;
    logic       wr_seg;
    logic       pix_dp;
    logic [3:0] mode_q;
    logic [3:0] mode_d;
    logic       restart_q;
    logic       restart_d;
    chan_t      v_min_q;
    chan_t      v_min_d;
    chan_t      v_max_q;
    chan_t      v_max_d;
    word_t      seg_q;
    word_t      seg_d;
    logic       rd_hit;
    word_t      rd_data;

    function automatic logic in_window(addr_t a);
        return a[31:9] == REG_BASE[31:9];
    endfunction

    // ----------------------------------------
    // Address phase capture
    // ----------------------------------------
    assign req_now = '{sel: HSELM, trans: HTRANSM, write: HWRITEM, addr: HADDRM};

    always_ff @(posedge HCLK)
    begin
        if (!HRESETn)
            req_q <= '0;
        else if (HREADYOUTM)
            req_q <= HTRANSM[1] ? req_now : '0;
    end

    assign dp_wr     = req_q.sel && req_q.trans[1] && req_q.write && in_window(req_q.addr);
    assign dp_idx    = req_q.addr[8:2];
    assign wr_ctrl   = dp_wr && (dp_idx == IDX_CTRL);
    assign wr_vrange = dp_wr && (dp_idx == IDX_V_RANGE);
    assign wr_seg    = dp_wr && (dp_idx == IDX_SEG);
    assign pix_dp    = dp_wr && (dp_idx == IDX_PIX);

    // Stretch a pixel write until the writer has room
    assign HREADYOUTM = !(pix_dp && !pix_ready);
    assign pix_in     = '{valid: pix_dp && pix_ready, data: HWDATAM[$bits(rgb_t)-1:0]};

    // ----------------------------------------
    // Register file
    // ----------------------------------------
    always_comb
    begin
        mode_d    = mode_q;
        restart_d = 1'b0;
        v_min_d   = v_min_q;
        v_max_d   = v_max_q;
        seg_d     = seg_q;
        if (wr_ctrl)
        begin
            mode_d    = HWDATAM[3:0];
            restart_d = HWDATAM[4];
        end
        if (wr_vrange)
        begin
            v_min_d = HWDATAM[3:0];
            v_max_d = HWDATAM[7:4];
        end
        if (wr_seg)
            seg_d = HWDATAM;
    end

    // Restart pending out of reset
    always_ff @(posedge HCLK)
    begin
        if (!HRESETn)
        begin
            mode_q    <= '0;
            restart_q <= 1'b1;
            v_min_q   <= '0;
            v_max_q   <= '0;
            seg_q     <= '0;
        end
        else
        begin
            mode_q    <= mode_d;
            restart_q <= restart_d;
            v_min_q   <= v_min_d;
            v_max_q   <= v_max_d;
            seg_q     <= seg_d;
        end
    end

    // ----------------------------------------
    // Read path, next values so a read right after a write sees it
    // ----------------------------------------
    assign rd_hit = HSELM && HTRANSM[1] && !HWRITEM && in_window(HADDRM);

    always_comb
    begin
        rd_data = '0;
        if (rd_hit)
        begin
            case (HADDRM[8:2])
                IDX_CTRL:    rd_data = word_t'({restart_d, mode_d});
                IDX_STATE:   rd_data = word_t'(status);
                IDX_V_RANGE: rd_data = word_t'({v_max_d, v_min_d});
                IDX_SEG:     rd_data = seg_d;
                default:     rd_data = '0;
            endcase
        end
    end

    always_ff @(posedge HCLK)
    begin
        if (HREADYOUTM)
            HRDATAM <= rd_data;
    end

    assign cfg      = '{mode: ipu_mode_e'(mode_q), v_min: v_min_q, v_max: v_max_q};
    assign restart  = restart_q;
    assign seg_word = seg_q;

    a_restart_pulse: assert property (@(posedge HCLK) disable iff (!HRESETn)
        restart_q |=> !restart_q);

endmodule

/* rtl/frame_ctrl.sv */
`timescale 1ns/1ps
`include "ipu_settings.svh"

module frame_ctrl
    import ipu_pkg::*;
#(
    parameter int FRAME_PIXELS = `IPU_FRAME_W * `IPU_FRAME_H
)
(
    input  logic        HCLK,
    input  logic        HRESETn,
    input  logic        restart,
    input  pix_beat_t   pix_in,
    input  logic        pix_done,
    output pix_beat_t   pix_accept,
    output ipu_status_t status
);

    localparam pix_cnt_t FULL = pix_cnt_t'(FRAME_PIXELS);
    localparam pix_cnt_t LAST = pix_cnt_t'(FRAME_PIXELS - 1);

    frame_state_e state;
    frame_state_e state_d;
    pix_cnt_t     in_cnt;
    pix_cnt_t     out_cnt;
    logic         accept;

    // Drop extra pixels and anything after the frame ends
    assign accept = pix_in.valid && !restart && (state != FS_END) && (in_cnt != FULL);

    always_comb
    begin
        state_d = state;
        case (state)
            FS_IDLE:
                if (accept)
                    state_d = FS_RUN;
            FS_RUN:
                if (pix_done && (out_cnt == LAST))
                    state_d = FS_END;
            FS_END:
                state_d = FS_END;
            default:
                state_d = FS_IDLE;
        endcase
        if (restart)
            state_d = FS_IDLE;
    end

    always_ff @(posedge HCLK)
    begin
        if (!HRESETn)
            state <= FS_IDLE;
        else
            state <= state_d;
    end

    always_ff @(posedge HCLK)
    begin
        if (!HRESETn || restart)
        begin
            in_cnt  <= '0;
            out_cnt <= '0;
        end
        else
        begin
            if (accept)
                in_cnt <= in_cnt + 1'b1;
            if (pix_done && (state == FS_RUN))
                out_cnt <= out_cnt + 1'b1;
        end
    end

    assign pix_accept = '{valid: accept, data: pix_in.data};

    assign status = '{
        output_done: state == FS_END,
        input_done:  in_cnt == FULL,
        running:     state == FS_RUN
    };

    a_end_quiet: assert property (@(posedge HCLK) disable iff (!HRESETn)
        (status.output_done && !restart) |=> !pix_accept.valid);

endmodule

/* rtl/pixel_binarize.sv */
`timescale 1ns/1ps

module pixel_binarize
    import ipu_pkg::*;
(
    input  logic      HCLK,
    input  logic      HRESETn,
    input  ipu_cfg_t  cfg,
    input  pix_beat_t pix_in,
    output pix_beat_t pix_out
);

    chan_t red;
    chan_t green;
    chan_t blue;
    chan_t value;
    logic  in_range;
    rgb_t  result;
    logic  out_valid;
    rgb_t  out_data;

    assign {red, green, blue} = pix_in.data;

    // HSV value is the brightest channel
    always_comb
    begin
        value = red;
        if (green > value)
            value = green;
        if (blue > value)
            value = blue;
    end

    assign in_range = (value >= cfg.v_min) && (value <= cfg.v_max);

    always_comb
    begin
        case (cfg.mode)
            MODE_BINARIZE: result = in_range ? '1 : '0;
            default:       result = pix_in.data;
        endcase
    end

    always_ff @(posedge HCLK)
    begin
        if (!HRESETn)
            out_valid <= 1'b0;
        else
            out_valid <= pix_in.valid;
    end

    always_ff @(posedge HCLK)
    begin
        if (pix_in.valid)
            out_data <= result;
    end

    assign pix_out = '{valid: out_valid, data: out_data};

endmodule

/* rtl/frame_writer.sv */
`timescale 1ns/1ps
`include "ipu_settings.svh"

module frame_writer
    import ipu_pkg::*;
(
    input  logic       HCLK,
    input  logic       HRESETn,
    input  logic       restart,
    input  pix_beat_t  pix_in,
    output logic       pix_ready,
    output logic       pix_done,
    output logic [1:0] HTRANSS,
    output addr_t      HADDRS,
    output logic       HWRITES,
    output word_t      HWDATAS,
    output logic       HREADYS,
    input  logic       HREADYOUTS
);

    localparam logic [1:0] TRANS_IDLE   = 2'b00;
    localparam logic [1:0] TRANS_NONSEQ = 2'b10;

    logic  buf_valid;
    logic  buf_valid_n;
    rgb_t  buf_data;
    logic  src_valid;
    rgb_t  src_data;
    logic  accept;
    logic  dp_valid;
    rgb_t  dp_data;
    addr_t out_addr;

    // Buffered word goes first, otherwise the fresh pixel
    assign src_valid = buf_valid || pix_in.valid;
    assign src_data  = buf_valid ? buf_data : pix_in.data;
    assign accept    = src_valid && HREADYOUTS;

    // ----------------------------------------
    // One-entry output buffer
    // ----------------------------------------
    always_comb
    begin
        if (buf_valid)
            buf_valid_n = !accept || pix_in.valid;
        else
            buf_valid_n = pix_in.valid && !accept;
    end

    // Room for the next stage beat
    assign pix_ready = !buf_valid_n;

    always_ff @(posedge HCLK)
    begin
        if (!HRESETn)
            buf_valid <= 1'b0;
        else
            buf_valid <= buf_valid_n;
    end

    always_ff @(posedge HCLK)
    begin
        if (pix_in.valid && (buf_valid || !accept))
            buf_data <= pix_in.data;
    end

    // ----------------------------------------
    // Data phase and output address
    // ----------------------------------------
    always_ff @(posedge HCLK)
    begin
        if (!HRESETn)
            dp_valid <= 1'b0;
        else if (HREADYOUTS)
            dp_valid <= accept;
    end

    always_ff @(posedge HCLK)
    begin
        if (accept)
            dp_data <= src_data;
    end

    always_ff @(posedge HCLK)
    begin
        if (!HRESETn || restart)
            out_addr <= `IPU_OUT_BASE;
        else if (accept)
            out_addr <= out_addr + 32'd4;
    end

    assign HTRANSS  = src_valid ? TRANS_NONSEQ : TRANS_IDLE;
    assign HWRITES  = src_valid;
    assign HADDRS   = out_addr;
    assign HWDATAS  = word_t'(dp_data);
    assign HREADYS  = HREADYOUTS;
    assign pix_done = dp_valid && HREADYOUTS;

    a_addr_hold: assert property (@(posedge HCLK) disable iff (!HRESETn || restart)
        (dp_valid && !HREADYOUTS) |=> $stable(HADDRS));

endmodule

/* rtl/seg_scan.sv */
`timescale 1ns/1ps
`include "ipu_settings.svh"

module seg_scan
    import ipu_pkg::*;
#(
    parameter int SEG_DIV = `IPU_SEG_DIV
)
(
    input  logic       HCLK,
    input  logic       HRESETn,
    input  word_t      seg_word,
    output logic [7:0] SEG_SELECT,
    output seg_t       SEG_DATA_OUT_0,
    output seg_t       SEG_DATA_OUT_1
);

    localparam int               DIV_W    = (SEG_DIV > 1) ? $clog2(SEG_DIV) : 1;
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(SEG_DIV - 1);

    logic [DIV_W-1:0] div_cnt;
    logic [1:0]       k;
    word_t            shifted;

    // Prescaler and scan index
    always_ff @(posedge HCLK)
    begin
        if (!HRESETn)
        begin
            div_cnt <= '0;
            k       <= '0;
        end
        else if (div_cnt == DIV_LAST)
        begin
            div_cnt <= '0;
            k       <= k + 1'b1;
        end
        else
        begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // Both halves of the display scan together
    assign SEG_SELECT = (8'b0000_0001 << k) | (8'b0001_0000 << k);

    // Digit k lands in the top nibble, digit k+4 sixteen bits lower
    assign shifted = seg_word << {k, 2'b00};

    assign SEG_DATA_OUT_0 = seg_hex(shifted[31:28]);
    assign SEG_DATA_OUT_1 = seg_hex(shifted[15:12]);

endmodule

/* rtl/ipu_top.sv */
`timescale 1ns/1ps
`include "ipu_settings.svh"

module ipu_top
    import ipu_pkg::*;
#(
    parameter int FRAME_PIXELS = `IPU_FRAME_W * `IPU_FRAME_H,
    parameter int SEG_DIV      = `IPU_SEG_DIV
)
(
    input  logic       HCLK,
    input  logic       HRESETn,

    // Slave port
    input  logic       HSELM,
    input  logic [1:0] HTRANSM,
    input  logic       HWRITEM,
    input  addr_t      HADDRM,
    input  word_t      HWDATAM,
    output logic       HREADYOUTM,
    output word_t      HRDATAM,

    // Master port
    output logic [1:0] HTRANSS,
    output addr_t      HADDRS,
    output logic       HWRITES,
    output word_t      HWDATAS,
    output logic       HREADYS,
    input  logic       HREADYOUTS,

    // Seven-segment display
    output logic [7:0] SEG_SELECT,
    output seg_t       SEG_DATA_OUT_0,
    output seg_t       SEG_DATA_OUT_1
);

    ipu_status_t status;
    ipu_cfg_t    cfg;
    logic        restart;
    logic        pix_ready;
    logic        pix_done;
    pix_beat_t   beat_raw;
    pix_beat_t   beat_acc;
    pix_beat_t   beat_out;
    word_t       seg_word;

    ipu_regs u_regs (
        .HCLK       (HCLK),
        .HRESETn    (HRESETn),
        .HSELM      (HSELM),
        .HTRANSM    (HTRANSM),
        .HWRITEM    (HWRITEM),
        .HADDRM     (HADDRM),
        .HWDATAM    (HWDATAM),
        .HREADYOUTM (HREADYOUTM),
        .HRDATAM    (HRDATAM),
        .status     (status),
        .pix_ready  (pix_ready),
        .cfg        (cfg),
        .restart    (restart),
        .pix_in     (beat_raw),
        .seg_word   (seg_word)
    );

    frame_ctrl #(
        .FRAME_PIXELS (FRAME_PIXELS)
    ) u_frame_ctrl (
        .HCLK       (HCLK),
        .HRESETn    (HRESETn),
        .restart    (restart),
        .pix_in     (beat_raw),
        .pix_done   (pix_done),
        .pix_accept (beat_acc),
        .status     (status)
    );

    pixel_binarize u_binarize (
        .HCLK    (HCLK),
        .HRESETn (HRESETn),
        .cfg     (cfg),
        .pix_in  (beat_acc),
        .pix_out (beat_out)
    );

    frame_writer u_writer (
        .HCLK       (HCLK),
        .HRESETn    (HRESETn),
        .restart    (restart),
        .pix_in     (beat_out),
        .pix_ready  (pix_ready),
        .pix_done   (pix_done),
        .HTRANSS    (HTRANSS),
        .HADDRS     (HADDRS),
        .HWRITES    (HWRITES),
        .HWDATAS    (HWDATAS),
        .HREADYS    (HREADYS),
        .HREADYOUTS (HREADYOUTS)
    );

    seg_scan #(
        .SEG_DIV (SEG_DIV)
    ) u_seg_scan (
        .HCLK           (HCLK),
        .HRESETn        (HRESETn),
        .seg_word       (seg_word),
        .SEG_SELECT     (SEG_SELECT),
        .SEG_DATA_OUT_0 (SEG_DATA_OUT_0),
        .SEG_DATA_OUT_1 (SEG_DATA_OUT_1)
    );

endmodule

/* tb/tb_ipu_ref.svh */
`ifndef TB_IPU_REF_SVH
`define TB_IPU_REF_SVH

// HSV value is the brightest of the three channels
function automatic chan_t ref_value(rgb_t p);
    chan_t v;
    v = p[11:8];
    if (p[7:4] > v)
        v = p[7:4];
    if (p[3:0] > v)
        v = p[3:0];
    return v;
endfunction

function automatic rgb_t ref_pixel(logic [3:0] mode, chan_t v_min, chan_t v_max, rgb_t p);
    chan_t v;
    v = ref_value(p);
    if (mode != 4'd1)
        return p;
    if (v >= v_min && v <= v_max)
        return 12'hFFF;
    return 12'h000;
endfunction

// Lit segments by letter, a is bit 0
function automatic seg_t ref_seg(logic [3:0] digit);
    string lit;
    seg_t  pat;
    int    pos;
    case (digit)
        4'h0:    lit = "abcdef";
        4'h1:    lit = "bc";
        4'h2:    lit = "abdeg";
        4'h3:    lit = "abcdg";
        4'h4:    lit = "bcfg";
        4'h5:    lit = "acdfg";
        4'h6:    lit = "acdefg";
        4'h7:    lit = "abc";
        4'h8:    lit = "abcdefg";
        4'h9:    lit = "abcdfg";
        4'hA:    lit = "abcefg";
        4'hB:    lit = "cdefg";
        4'hC:    lit = "adef";
        4'hD:    lit = "bcdeg";
        4'hE:    lit = "adefg";
        default: lit = "aefg";
    endcase
    pat = '0;
    for (int i = 0; i < lit.len(); i++)
    begin
        pos = int'(lit[i]) - 97;
        pat[pos[2:0]] = 1'b1;
    end
    return pat;
endfunction

task automatic check_word(input string name, input word_t exp, input word_t act);
    if (exp !== act)
    begin
        $display("Fail %s: expected %h, actual %h", name, exp, act);
        value_errs++;
    end
endtask

task automatic check_pix(input string name, input rgb_t exp, input rgb_t act);
    if (exp !== act)
    begin
        $display("Fail %s: expected %h, actual %h", name, exp, act);
        value_errs++;
    end
endtask

task automatic check_seg(input string name, input seg_t exp, input seg_t act);
    if (exp !== act)
    begin
        $display("Fail %s: expected %h, actual %h", name, exp, act);
        value_errs++;
    end
endtask

`endif

/* tb/tb_ipu.sv */
`timescale 1ns/1ps
`include "ipu_settings.svh"

module tb_ipu
    import ipu_pkg::*;
();

    localparam int    FRAME_PIXELS = 64;
    localparam int    SEG_DIV      = 4;
    localparam addr_t REG_BASE     = `IPU_REG_BASE;
    localparam addr_t OUT_BASE     = `IPU_OUT_BASE;
    localparam int    WAIT_LIMIT   = 200;
    localparam int    DRAIN_LIMIT  = 4000;

    logic       HCLK;
    logic       HRESETn;
    logic       HSELM;
    logic [1:0] HTRANSM;
    logic       HWRITEM;
    addr_t      HADDRM;
    word_t      HWDATAM;
    logic       HREADYOUTM;
    word_t      HRDATAM;
    logic [1:0] HTRANSS;
    addr_t      HADDRS;
    logic       HWRITES;
    word_t      HWDATAS;
    logic       HREADYS;
    logic       HREADYOUTS;
    logic [7:0] SEG_SELECT;
    seg_t       SEG_DATA_OUT_0;
    seg_t       SEG_DATA_OUT_1;

    int         value_errs;
    int         other_errs;
    int         stall_pct;
    int         stretch_cycles;
    int         frame_in;
    int         i;
    logic [3:0] cur_mode;
    chan_t      cur_v_min;
    chan_t      cur_v_max;
    addr_t      exp_addr_q[$];
    rgb_t       exp_pix_q[$];
    addr_t      obs_addr_q[$];
    word_t      obs_data_q[$];
    word_t      mem[addr_t];
    logic       dp_pending;
    addr_t      dp_addr;
    addr_t      obs_a;
    word_t      obs_d;
    word_t      rd;

    `include "tb_ipu_ref.svh"

    ipu_top #(
        .FRAME_PIXELS (FRAME_PIXELS),
        .SEG_DIV      (SEG_DIV)
    ) dut0 (.*);

    initial
    begin
        HCLK = 1'b0;
        forever #4 HCLK = ~HCLK;
    end

    // ----------------------------------------
    // Output memory model
    // ----------------------------------------
    initial
    begin
        HREADYOUTS = 1'b1;
        forever
        begin
            @(posedge HCLK);
            #1;
            HREADYOUTS = (stall_pct == 0) || (($urandom % 100) >= stall_pct);
        end
    end

    // Bus is stable at the falling edge, acts on the next rising edge
    always @(negedge HCLK)
    begin
        if (!HRESETn)
            dp_pending = 1'b0;
        else
        begin
            // Single slave, so its ready goes straight back out
            check_word("master hready", word_t'(HREADYOUTS), word_t'(HREADYS));
            if (HREADYOUTS)
            begin
                if (dp_pending)
                begin
                    mem[dp_addr] = HWDATAS;
                    obs_addr_q.push_back(dp_addr);
                    obs_data_q.push_back(HWDATAS);
                end
                dp_pending = HTRANSS[1] && HWRITES;
                dp_addr    = HADDRS;
            end
        end
    end

    always @(posedge HCLK)
    begin
        while (obs_addr_q.size() > 0)
        begin
            obs_a = obs_addr_q.pop_front();
            obs_d = obs_data_q.pop_front();
            if (exp_addr_q.size() == 0)
            begin
                $display("Output write to %h with no pixel pending", obs_a);
                other_errs++;
            end
            else
            begin
                check_word("out addr", exp_addr_q.pop_front(), obs_a);
                check_pix("out pixel", exp_pix_q.pop_front(), obs_d[11:0]);
                check_word("out upper bits", 32'h0, obs_d & 32'hFFFF_F000);
            end
        end
    end

    // ----------------------------------------
    // Slave bus tasks
    // ----------------------------------------
    task automatic bus_xfer(input addr_t a, input logic wr, input word_t wd, output word_t rdata);
        int n;
        n = 0;
        @(posedge HCLK);
        #1;
        HSELM   = 1'b1;
        HTRANSM = 2'b10;
        HWRITEM = wr;
        HADDRM  = a;
        @(posedge HCLK);
        #1;
        HSELM   = 1'b0;
        HTRANSM = 2'b00;
        HWRITEM = 1'b0;
        if (wr)
            HWDATAM = wd;
        @(negedge HCLK);
        while (!HREADYOUTM && n < WAIT_LIMIT)
        begin
            n++;
            @(negedge HCLK);
        end
        stretch_cycles += n;
        rdata = HRDATAM;
        if (!HREADYOUTM)
        begin
            $display("Slave transfer to %h never completed", a);
            other_errs++;
        end
        @(posedge HCLK);
    endtask

    task automatic write_reg(input addr_t a, input word_t d);
        word_t ignored;
        bus_xfer(a, 1'b1, d, ignored);
    endtask

    task automatic read_reg(input addr_t a, output word_t d);
        bus_xfer(a, 1'b0, 32'h0, d);
    endtask

    // Only the first FRAME_PIXELS inputs of a frame come out
    task automatic write_pixel(input rgb_t p);
        word_t ignored;
        if (frame_in < FRAME_PIXELS)
        begin
            exp_addr_q.push_back(OUT_BASE + addr_t'(4 * frame_in));
            exp_pix_q.push_back(ref_pixel(cur_mode, cur_v_min, cur_v_max, p));
        end
        frame_in++;
        bus_xfer(REG_BASE + `IPU_OFS_PIX_IN, 1'b1, {20'($urandom), p}, ignored);
    endtask

    task automatic set_range(input chan_t v_min, input chan_t v_max);
        write_reg(REG_BASE + `IPU_OFS_V_RANGE, {24'h0, v_max, v_min});
        cur_v_min = v_min;
        cur_v_max = v_max;
    endtask

    task automatic restart_frame(input ipu_mode_e mode);
        write_reg(REG_BASE + `IPU_OFS_CTRL, 32'h10 | word_t'(mode));
        cur_mode = mode;
        frame_in = 0;
    endtask

    task automatic wait_drain(input string what);
        int n;
        n = 0;
        @(negedge HCLK);
        while (exp_addr_q.size() > 0 && n < DRAIN_LIMIT)
        begin
            n++;
            @(negedge HCLK);
        end
        if (exp_addr_q.size() > 0)
        begin
            $display("%s: %0d output words never arrived", what, exp_addr_q.size());
            other_errs++;
            exp_addr_q.delete();
            exp_pix_q.delete();
        end
    endtask

    // Sample at each change of the digit select
    task automatic check_display(input word_t w, input int steps);
        logic [7:0] prev_sel;
        logic [7:0] exp_sel;
        logic [1:0] k;
        logic [1:0] next_k;
        logic [3:0] d0;
        logic [3:0] d1;
        int         n;
        @(negedge HCLK);
        prev_sel = SEG_SELECT;
        next_k   = 2'd0;
        for (int s = 0; s < steps; s++)
        begin
            n = 0;
            @(negedge HCLK);
            while (SEG_SELECT == prev_sel && n < 4 * SEG_DIV)
            begin
                n++;
                @(negedge HCLK);
            end
            if (SEG_SELECT == prev_sel)
            begin
                $display("Display select stuck at %b", SEG_SELECT);
                other_errs++;
                return;
            end
            prev_sel = SEG_SELECT;
            k = 2'd0;
            for (int b = 0; b < 4; b++)
                if (SEG_SELECT[b])
                    k = 2'(b);
            if (s > 0)
                check_word("seg index", word_t'(next_k), word_t'(k));
            next_k     = k + 2'd1;
            exp_sel    = 8'h00;
            exp_sel[k] = 1'b1;
            exp_sel[k + 3'd4] = 1'b1;
            d0         = 4'(w >> (28 - 4 * int'(k)));
            d1         = 4'(w >> (12 - 4 * int'(k)));
            check_word("seg select", word_t'(exp_sel), word_t'(SEG_SELECT));
            check_seg("seg digit k", ref_seg(d0), SEG_DATA_OUT_0);
            check_seg("seg digit k+4", ref_seg(d1), SEG_DATA_OUT_1);
        end
    endtask

    initial
    begin
        void'($urandom(32'ha3b8_bd4b));
        HRESETn        = 1'b0;
        HSELM          = 1'b0;
        HTRANSM        = 2'b00;
        HWRITEM        = 1'b0;
        HADDRM         = '0;
        HWDATAM        = '0;
        value_errs     = 0;
        other_errs     = 0;
        stall_pct      = 0;
        stretch_cycles = 0;
        frame_in       = 0;
        cur_mode       = 4'd0;
        cur_v_min      = '0;
        cur_v_max      = '0;
        repeat (4) @(posedge HCLK);
        #1;
        HRESETn = 1'b1;

        // Bus outputs out of reset
        check_word("htrans after reset", 32'h0, word_t'(HTRANSS));
        check_word("hwrite after reset", 32'h0, word_t'(HWRITES));
        check_word("hreadyout after reset", 32'h1, word_t'(HREADYOUTM));

        // ----------------------------------------
        // Register access
        // ----------------------------------------
        read_reg(REG_BASE + `IPU_OFS_STATE, rd);
        check_word("state after reset", 32'h0, rd);
        write_reg(REG_BASE + `IPU_OFS_CTRL, 32'h1);
        read_reg(REG_BASE + `IPU_OFS_CTRL, rd);
        check_word("ctrl binarize", 32'h1, rd);
        write_reg(REG_BASE + `IPU_OFS_CTRL, 32'h0);
        read_reg(REG_BASE + `IPU_OFS_CTRL, rd);
        check_word("ctrl original", 32'h0, rd);
        set_range(4'h3, 4'hC);
        read_reg(REG_BASE + `IPU_OFS_V_RANGE, rd);
        check_word("v_range", 32'hC3, rd);
        write_reg(REG_BASE + `IPU_OFS_SEG, 32'hDEAD_BEEF);
        read_reg(REG_BASE + `IPU_OFS_SEG, rd);
        check_word("seg", 32'hDEAD_BEEF, rd);
        write_reg(REG_BASE + 32'h008, 32'hFFFF_FFFF);
        read_reg(REG_BASE + 32'h008, rd);
        check_word("unmapped in window", 32'h0, rd);
        read_reg(REG_BASE + 32'h200, rd);
        check_word("outside window", 32'h0, rd);

        // ----------------------------------------
        // Original frame, then extra pixels
        // ----------------------------------------
        for (i = 0; i < FRAME_PIXELS; i++)
            write_pixel(rgb_t'($urandom));
        wait_drain("original frame");
        read_reg(REG_BASE + `IPU_OFS_STATE, rd);
        check_word("state frame end", 32'h6, rd);
        for (i = 0; i < 3; i++)
            write_pixel(rgb_t'($urandom));
        repeat (30) @(posedge HCLK);
        read_reg(REG_BASE + `IPU_OFS_STATE, rd);
        check_word("state after extras", 32'h6, rd);

        // Binarize frame from a fresh output address
        set_range(4'd5, 4'd11);
        restart_frame(MODE_BINARIZE);
        read_reg(REG_BASE + `IPU_OFS_STATE, rd);
        check_word("state after restart", 32'h0, rd);
        for (i = 0; i < FRAME_PIXELS; i++)
            write_pixel(rgb_t'($urandom));
        wait_drain("binarize frame");
        read_reg(REG_BASE + `IPU_OFS_STATE, rd);
        check_word("state binarize end", 32'h6, rd);

        // ----------------------------------------
        // Back-pressure on the master port
        // ----------------------------------------
        restart_frame(MODE_ORIGINAL);
        stall_pct      = 75;
        stretch_cycles = 0;
        for (i = 0; i < FRAME_PIXELS + 2; i++)
            write_pixel(rgb_t'($urandom));
        read_reg(REG_BASE + `IPU_OFS_STATE, rd);
        check_word("state input done", 32'h2, rd & 32'h2);
        wait_drain("stalled frame");
        stall_pct = 0;
        if (stretch_cycles == 0)
        begin
            $display("Slave never stretched a pixel write under back-pressure");
            other_errs++;
        end
        read_reg(REG_BASE + `IPU_OFS_STATE, rd);
        check_word("state stalled end", 32'h6, rd);
        check_word("stored words", 32'd64, word_t'(mem.num()));

        // Display scan
        write_reg(REG_BASE + `IPU_OFS_SEG, 32'h0123_4567);
        check_display(32'h0123_4567, 8);

        repeat (4) @(posedge HCLK);
        $display("Summary: %0d value errors, %0d other errors", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

/* project.f */
+incdir+rtl
+incdir+tb
rtl/ipu_pkg.sv
rtl/ipu_regs.sv
rtl/frame_ctrl.sv
rtl/pixel_binarize.sv
rtl/frame_writer.sv
rtl/seg_scan.sv
rtl/ipu_top.sv
tb/tb_ipu.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_ipu
FILELIST   := project.f
FLAGS      := --timing --assert
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := *** FAILED ***
PASS_MSG   := *** PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then \
		echo "Simulation reported errors, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -qF '$(PASS_MSG)' $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
